/* lc3b_rob_pkg.sv */
package lc3b_rob_pkg;

	// lc3b opcode field, bits [15:12] of the instruction.
	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// eight architectural registers.
	typedef enum logic [2:0] {r0, r1, r2, r3, r4, r5, r6, r7} lc3b_reg;

	// four-phase intake states.
	typedef enum logic [1:0] {idle, write, ack_wait} disp_state;

	// entries whose value is known when they enter the buffer.
	function automatic logic done_at_dispatch(input lc3b_opcode op);
		case (op)
			op_br, op_lea, op_jsr, op_str, op_stb, op_sti: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// opcodes that retire into the register file.
	function automatic logic writes_reg(input lc3b_opcode op);
		case (op)
			op_add, op_and, op_not, op_shf: return 1'b1; // alu ops.
			op_ldb, op_ldr, op_ldi, op_lea, op_jsr: return 1'b1; // loads, lea, link.
			default: return 1'b0;
		endcase
	endfunction

endpackage

/* rob_storage.sv */
`timescale 1ns/1ps

module rob_storage #(
	parameter data_width = 16,
	parameter tag_width = 3
)
(
	input logic clk,
	input logic rst,
	input logic we, // allocate at tail.
	input logic re, // retire head.
	input logic flush,
	input lc3b_rob_pkg::lc3b_opcode inst_in,
	input lc3b_rob_pkg::lc3b_reg dest_in,
	input logic [data_width-1:0] value_in,
	input logic predict_in,
	input logic cdb_valid,
	input logic [tag_width-1:0] cdb_tag,
	input logic [data_width-1:0] cdb_value,
	input logic [tag_width-1:0] src1_tag,
	input logic [tag_width-1:0] src2_tag,
	output lc3b_rob_pkg::lc3b_opcode head_inst,
	output lc3b_rob_pkg::lc3b_reg head_dest,
	output logic [data_width-1:0] head_value,
	output logic head_valid,
	output logic head_predict,
	output logic [tag_width-1:0] w_addr,
	output logic empty,
	output logic full,
	output logic [data_width-1:0] src1_value,
	output logic src1_ready,
	output logic [data_width-1:0] src2_value,
	output logic src2_ready
);

	localparam int depth = 2**tag_width;
	localparam logic [tag_width:0] full_cnt = (tag_width+1)'(depth);

	// per-entry fields.
	lc3b_rob_pkg::lc3b_opcode inst_mem [0:depth-1];
	lc3b_rob_pkg::lc3b_reg dest_mem [0:depth-1];
	logic [data_width-1:0] value_mem [0:depth-1];
	logic predict_mem [0:depth-1];
	logic valid_mem [0:depth-1]; // value is final.

	logic [tag_width-1:0] head; // oldest entry.
	logic [tag_width-1:0] tail; // next free slot.
	logic [tag_width:0] cnt; // one extra bit to tell full from empty.
	logic do_write;
	logic do_read;
	logic [tag_width-1:0] cdb_off; // distance of strobe tag from head.

	assign empty = (cnt == '0);
	assign full = (cnt == full_cnt);
	assign do_write = we && !full;
	assign do_read = re && !empty;
	assign w_addr = tail;

	// head view for commit.
	assign head_inst = inst_mem[head];
	assign head_dest = dest_mem[head];
	assign head_value = value_mem[head];
	assign head_valid = valid_mem[head];
	assign head_predict = predict_mem[head];

	// operand forwarding, straight array reads.
	assign src1_value = value_mem[src1_tag];
	assign src1_ready = valid_mem[src1_tag];
	assign src2_value = value_mem[src2_tag];
	assign src2_ready = valid_mem[src2_tag];

	// payload fields.
	always_ff @(posedge clk)
	begin
		if (do_write)
		begin
			inst_mem[tail] <= inst_in;
			dest_mem[tail] <= dest_in;
			value_mem[tail] <= value_in; // branch outcome or early result.
			predict_mem[tail] <= predict_in;
		end
		if (cdb_valid)
			value_mem[cdb_tag] <= cdb_value; // late result fills in by tag.
	end

	// pointers, count and valid flags.
	always_ff @(posedge clk)
	begin
		if (rst || flush)
		begin
			head <= '0;
			tail <= '0;
			cnt <= '0;
			for (int i = 0; i < depth; i++)
				valid_mem[i] <= 1'b0;
		end
		else
		begin
			if (do_write)
			begin
				valid_mem[tail] <= lc3b_rob_pkg::done_at_dispatch(inst_in);
				tail <= tail + tag_width'(1);
			end
			if (cdb_valid)
				valid_mem[cdb_tag] <= 1'b1;
			if (do_read)
			begin
				valid_mem[head] <= 1'b0; // slot free again.
				head <= head + tag_width'(1);
			end
			case ({do_write, do_read})
				2'b10: cnt <= cnt + (tag_width+1)'(1);
				2'b01: cnt <= cnt - (tag_width+1)'(1);
				default: cnt <= cnt; // both or neither.
			endcase
		end
	end

	assign cdb_off = cdb_tag - head;

	// dispatch must hold off while the buffer is full.
	a_no_write_full: assert property (@(posedge clk) disable iff (rst)
		we |-> !full);

	// commit only retires a real entry.
	a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
		re |-> !empty);

	// a result must target an allocated slot.
	a_cdb_occupied: assert property (@(posedge clk) disable iff (rst || flush)
		cdb_valid |-> ({1'b0, cdb_off} < cnt));

endmodule

/* rob_dispatch.sv */
`timescale 1ns/1ps

module rob_dispatch #(
	parameter tag_width = 3
)
(
	input logic clk,
	input logic rst,
	input logic disp_req, // four-phase request from the front end.
	input logic full,
	input logic flush,
	input logic [tag_width-1:0] w_addr, // current tail of the buffer.
	output logic we,
	output logic disp_ack,
	output logic [tag_width-1:0] disp_tag
);

	lc3b_rob_pkg::disp_state state;
	lc3b_rob_pkg::disp_state state_next;
	logic [tag_width-1:0] tag_q; // slot handed to this request.

	// write lasts one cycle, held back while a flush is in progress.
	assign we = (state == lc3b_rob_pkg::write) && !flush;
	assign disp_ack = (state == lc3b_rob_pkg::ack_wait);
	assign disp_tag = tag_q;

	always_comb
	begin
		state_next = state;
		case (state)
			lc3b_rob_pkg::idle:
			begin
				// stay here while full, that is the back-pressure.
				if (disp_req && !full)
					state_next = lc3b_rob_pkg::write;
			end
			lc3b_rob_pkg::write:
			begin
				if (!flush)
					state_next = lc3b_rob_pkg::ack_wait; // entry lands on this edge.
			end
			lc3b_rob_pkg::ack_wait:
			begin
				if (!disp_req)
					state_next = lc3b_rob_pkg::idle; // req dropped, release ack.
			end
			default: state_next = lc3b_rob_pkg::idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= lc3b_rob_pkg::idle;
		else
			state <= state_next;
	end

	// remember the slot, tail moves on after the write.
	always_ff @(posedge clk)
	begin
		if (we)
			tag_q <= w_addr;
	end

	// ack only answers a request that is still up.
	a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(disp_ack) |-> disp_req);

endmodule

/* rob_commit.sv */
`timescale 1ns/1ps

module rob_commit #(
	parameter data_width = 16
)
(
	input logic clk,
	input logic rst,
	input logic empty,
	input lc3b_rob_pkg::lc3b_opcode head_inst,
	input lc3b_rob_pkg::lc3b_reg head_dest,
	input logic [data_width-1:0] head_value,
	input logic head_valid,
	input logic head_predict,
	output logic re,
	output logic flush,
	output logic rf_we,
	output lc3b_rob_pkg::lc3b_reg rf_dest,
	output logic [data_width-1:0] rf_data,
	output logic commit_valid,
	output lc3b_rob_pkg::lc3b_opcode commit_inst,
	output lc3b_rob_pkg::lc3b_reg commit_dest,
	output logic [data_width-1:0] commit_value,
	output logic mispredict
);

	logic is_branch;
	logic wrong_path; // predicted direction differs from outcome.

	assign is_branch = (head_inst == lc3b_rob_pkg::op_br);
	assign wrong_path = is_branch && (head_predict != head_value[0]);

	// retire the head once its value is in, never while flushing.
	assign re = !empty && head_valid && !flush;

	// flush is the registered mispredict, live for one cycle.
	assign flush = mispredict;

	// register write uses the committed copy, one cycle behind commit_valid.
	assign rf_dest = commit_dest;
	assign rf_data = commit_value;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			commit_valid <= 1'b0;
			rf_we <= 1'b0;
			mispredict <= 1'b0;
		end
		else
		begin
			commit_valid <= re;
			rf_we <= re && lc3b_rob_pkg::writes_reg(head_inst); // stores and branches skip.
			mispredict <= re && wrong_path;
		end
	end

	// retired entry as seen from outside.
	always_ff @(posedge clk)
	begin
		if (re)
		begin
			commit_inst <= head_inst;
			commit_dest <= head_dest;
			commit_value <= head_value;
		end
	end

endmodule

/* arch_regfile.sv */
`timescale 1ns/1ps

module arch_regfile #(
	parameter data_width = 16
)
(
	input logic clk,
	input logic rst,
	input logic we,
	input lc3b_rob_pkg::lc3b_reg dest,
	input logic [data_width-1:0] data,
	input lc3b_rob_pkg::lc3b_reg sel, // read select.
	output logic [data_width-1:0] value
);

	logic [data_width-1:0] regs [0:7]; // r0 to r7.

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end
		else if (we)
		begin
			regs[dest] <= data; // one write per cycle from commit.
		end
	end

	// read is combinational, a write shows up after the edge.
	assign value = regs[sel];

endmodule

/* rob_top.sv */
`timescale 1ns/1ps

module rob_top #(
	parameter data_width = 16,
	parameter tag_width = 3
)
(
	input logic clk,
	input logic rst,
	input logic disp_req,
	input lc3b_rob_pkg::lc3b_opcode disp_inst,
	input lc3b_rob_pkg::lc3b_reg disp_dest,
	input logic [data_width-1:0] disp_value, // bit 0 is the outcome for op_br.
	input logic disp_predict,
	output logic disp_ack,
	output logic [tag_width-1:0] disp_tag,
	input logic cdb_valid,
	input logic [tag_width-1:0] cdb_tag,
	input logic [data_width-1:0] cdb_value,
	input logic [tag_width-1:0] src1_tag,
	input logic [tag_width-1:0] src2_tag,
	output logic [data_width-1:0] src1_value,
	output logic src1_ready,
	output logic [data_width-1:0] src2_value,
	output logic src2_ready,
	output logic commit_valid,
	output lc3b_rob_pkg::lc3b_opcode commit_inst,
	output lc3b_rob_pkg::lc3b_reg commit_dest,
	output logic [data_width-1:0] commit_value,
	output logic mispredict,
	input lc3b_rob_pkg::lc3b_reg reg_sel,
	output logic [data_width-1:0] reg_value
);

	logic we;
	logic re;
	logic flush;
	logic full;
	logic empty;
	logic [tag_width-1:0] w_addr;
	lc3b_rob_pkg::lc3b_opcode head_inst;
	lc3b_rob_pkg::lc3b_reg head_dest;
	logic [data_width-1:0] head_value;
	logic head_valid;
	logic head_predict;
	logic rf_we;
	lc3b_rob_pkg::lc3b_reg rf_dest;
	logic [data_width-1:0] rf_data;

	rob_dispatch #(.tag_width(tag_width)) u_dispatch (
		.clk(clk), .rst(rst), .disp_req(disp_req), .full(full), .flush(flush),
		.w_addr(w_addr), .we(we), .disp_ack(disp_ack), .disp_tag(disp_tag)
	);

	rob_storage #(.data_width(data_width), .tag_width(tag_width)) u_storage (
		.clk(clk), .rst(rst), .we(we), .re(re), .flush(flush),
		.inst_in(disp_inst), .dest_in(disp_dest), .value_in(disp_value),
		.predict_in(disp_predict), .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
		.cdb_value(cdb_value), .src1_tag(src1_tag), .src2_tag(src2_tag),
		.head_inst(head_inst), .head_dest(head_dest), .head_value(head_value),
		.head_valid(head_valid), .head_predict(head_predict), .w_addr(w_addr),
		.empty(empty), .full(full), .src1_value(src1_value), .src1_ready(src1_ready),
		.src2_value(src2_value), .src2_ready(src2_ready)
	);

	rob_commit #(.data_width(data_width)) u_commit (
		.clk(clk), .rst(rst), .empty(empty), .head_inst(head_inst),
		.head_dest(head_dest), .head_value(head_value), .head_valid(head_valid),
		.head_predict(head_predict), .re(re), .flush(flush), .rf_we(rf_we),
		.rf_dest(rf_dest), .rf_data(rf_data), .commit_valid(commit_valid),
		.commit_inst(commit_inst), .commit_dest(commit_dest),
		.commit_value(commit_value), .mispredict(mispredict)
	);

	arch_regfile #(.data_width(data_width)) u_regfile (
		.clk(clk), .rst(rst), .we(rf_we), .dest(rf_dest), .data(rf_data),
		.sel(reg_sel), .value(reg_value)
	);

endmodule

/* tb_rob.sv */
`timescale 1ns/1ps

module tb_rob;

	localparam int data_width = 16;
	localparam int tag_width = 3;
	localparam int depth = 2**tag_width;
	localparam int half_period = 20; // 40 ns clock.
	localparam int drive_delay = 2;
	localparam int ack_timeout = 200; // in cycles.
	localparam int stall_cycles = 24; // no ack expected while full.
	localparam int num_random = 240;
	localparam logic [31:0] seed = 32'he00e_779a;

	typedef struct packed
	{
		lc3b_rob_pkg::lc3b_opcode inst;
		lc3b_rob_pkg::lc3b_reg dest;
		logic [data_width-1:0] value;
		logic predict;
		logic done; // result is known.
		logic [tag_width-1:0] tag;
	} rob_entry;

	logic clk;
	logic rst;
	logic disp_req;
	lc3b_rob_pkg::lc3b_opcode disp_inst;
	lc3b_rob_pkg::lc3b_reg disp_dest;
	logic [data_width-1:0] disp_value;
	logic disp_predict;
	logic disp_ack;
	logic [tag_width-1:0] disp_tag;
	logic cdb_valid;
	logic [tag_width-1:0] cdb_tag;
	logic [data_width-1:0] cdb_value;
	logic [tag_width-1:0] src1_tag;
	logic [tag_width-1:0] src2_tag;
	logic [data_width-1:0] src1_value;
	logic src1_ready;
	logic [data_width-1:0] src2_value;
	logic src2_ready;
	logic commit_valid;
	lc3b_rob_pkg::lc3b_opcode commit_inst;
	lc3b_rob_pkg::lc3b_reg commit_dest;
	logic [data_width-1:0] commit_value;
	logic mispredict;
	lc3b_rob_pkg::lc3b_reg reg_sel;
	logic [data_width-1:0] reg_value;

	rob_entry model_q [$]; // in flight, oldest first.
	rob_entry pend; // entry held on the dispatch bus.
	logic [data_width-1:0] model_regs [0:7];
	logic [tag_width-1:0] model_tail;
	logic ack_q; // ack at the previous sample.
	logic completion_on;
	logic reg_watch_on; // a register write has just retired.
	lc3b_rob_pkg::lc3b_reg reg_watch;
	int errors;
	int failures;
	int commits;
	int mispredicts;

	rob_top #(.data_width(data_width), .tag_width(tag_width)) u_dut (.*);

	always #(half_period) clk = ~clk;

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("failure at %0t ns: %s", $time, what);
	endtask

	// value known when the entry enters the buffer.
	function automatic logic early_ready(input lc3b_rob_pkg::lc3b_opcode op);
		return op inside {lc3b_rob_pkg::op_br, lc3b_rob_pkg::op_lea, lc3b_rob_pkg::op_jsr,
			lc3b_rob_pkg::op_str, lc3b_rob_pkg::op_stb, lc3b_rob_pkg::op_sti};
	endfunction

	// opcodes that land in the register file at retirement.
	function automatic logic changes_reg(input lc3b_rob_pkg::lc3b_opcode op);
		return op inside {lc3b_rob_pkg::op_add, lc3b_rob_pkg::op_and, lc3b_rob_pkg::op_not,
			lc3b_rob_pkg::op_shf, lc3b_rob_pkg::op_ldb, lc3b_rob_pkg::op_ldr,
			lc3b_rob_pkg::op_ldi, lc3b_rob_pkg::op_lea, lc3b_rob_pkg::op_jsr};
	endfunction

	// every 20th entry is a branch predicted the wrong way.
	function automatic rob_entry random_entry(input int n, input logic force_op,
		input lc3b_rob_pkg::lc3b_opcode op);
		rob_entry e;
		e.inst = force_op ? op : lc3b_rob_pkg::lc3b_opcode'(4'($urandom));
		e.dest = lc3b_rob_pkg::lc3b_reg'(3'($urandom));
		e.value = data_width'($urandom);
		e.predict = 1'($urandom);
		if (n % 20 == 19)
		begin
			e.inst = lc3b_rob_pkg::op_br;
			e.predict = !e.value[0];
		end
		e.done = early_ready(e.inst);
		e.tag = '0;
		return e;
	endfunction

	task automatic send_request(input rob_entry e);
		@(posedge clk);
		#(drive_delay);
		pend = e;
		disp_inst = e.inst;
		disp_dest = e.dest;
		disp_value = e.value;
		disp_predict = e.predict;
		src2_tag = model_tail; // slot it should get.
		disp_req = 1'b1;
	endtask

	task automatic wait_ack(input int limit, output logic got);
		int n;
		got = 1'b0;
		n = 0;
		while (!got && n < limit)
		begin
			@(negedge clk);
			got = disp_ack;
			n++;
		end
	endtask

	// phases three and four.
	task automatic release_request();
		int n;
		@(posedge clk);
		#(drive_delay);
		disp_req = 1'b0;
		n = 0;
		@(negedge clk);
		while (disp_ack && n < ack_timeout)
		begin
			@(negedge clk);
			n++;
		end
		if (disp_ack)
			report_failure("disp_ack stayed high after req was dropped");
	endtask

	task automatic dispatch_one(input rob_entry e);
		logic got;
		send_request(e);
		wait_ack(ack_timeout, got);
		if (!got)
			report_failure("no disp_ack within the timeout");
		release_request();
	endtask

	// registers are swept while rst is still high.
	task automatic check_reset_state();
		int r;
		for (r = 0; r < 8; r++)
		begin
			@(posedge clk);
			#(drive_delay);
			reg_sel = lc3b_rob_pkg::lc3b_reg'(3'(r));
			@(negedge clk);
			if (reg_value !== '0)
				report_mismatch("reg_value", 32'(reg_value), 32'h0);
			if (disp_ack !== 1'b0 || commit_valid !== 1'b0 || mispredict !== 1'b0)
				report_failure("disp_ack, commit_valid or mispredict high in reset");
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (model_q.size() != 0 && n < 4 * ack_timeout)
		begin
			@(negedge clk);
			n++;
		end
		if (model_q.size() != 0)
			report_failure("buffer did not drain within the timeout");
		repeat (3) @(negedge clk); // last register writes settle.
	endtask

	// model of the buffer updated at the falling edge.
	always @(negedge clk)
	begin
		rob_entry head;
		logic exp_mis;
		if (!rst)
		begin
			if (disp_ack && !ack_q)
			begin
				if (disp_tag !== model_tail)
					report_mismatch("disp_tag", 32'(disp_tag), 32'(model_tail));
				pend.tag = disp_tag;
				model_q.push_back(pend);
				model_tail = model_tail + tag_width'(1);
				if (pend.done && src2_tag == disp_tag)
				begin
					if (src2_ready !== 1'b1)
						report_mismatch("src2_ready", 32'(src2_ready), 32'h1);
					if (src2_value !== pend.value)
						report_mismatch("src2_value", 32'(src2_value), 32'(pend.value));
				end
			end
			// the file lags the commit by a cycle so the check comes before this commit.
			if (reg_value !== model_regs[reg_sel])
				report_mismatch("reg_value", 32'(reg_value), 32'(model_regs[reg_sel]));
			if (commit_valid && model_q.size() == 0)
				report_failure("commit with no entry in flight");
			else if (commit_valid)
			begin
				head = model_q.pop_front();
				commits++;
				if (commit_inst !== head.inst)
					report_mismatch("commit_inst", 32'(commit_inst), 32'(head.inst));
				if (commit_dest !== head.dest)
					report_mismatch("commit_dest", 32'(commit_dest), 32'(head.dest));
				if (commit_value !== head.value)
					report_mismatch("commit_value", 32'(commit_value), 32'(head.value));
				if (!head.done)
					report_failure("entry committed before its result arrived");
				if (changes_reg(head.inst))
				begin
					model_regs[head.dest] = head.value;
					reg_watch = head.dest;
					reg_watch_on = 1'b1;
				end
				exp_mis = (head.inst == lc3b_rob_pkg::op_br) && (head.predict != head.value[0]);
				if (mispredict !== exp_mis)
					report_mismatch("mispredict", 32'(mispredict), 32'(exp_mis));
				if (exp_mis)
				begin
					model_q.delete(); // wrong-path entries are gone.
					model_tail = '0;
					mispredicts++;
				end
			end
			else if (mispredict)
				report_failure("mispredict without a commit");
		end
		ack_q = disp_ack;
	end

	// result bus strobes and a read-port check one cycle later.
	initial
	begin
		int n_open;
		int pick;
		int idx;
		logic check_pending;
		logic [data_width-1:0] chk_value;
		rob_entry e;
		check_pending = 1'b0;
		chk_value = '0;
		forever
		begin
			@(posedge clk);
			#(drive_delay);
			cdb_valid = 1'b0;
			if (!rst)
			begin
				reg_sel = reg_watch_on ? reg_watch : lc3b_rob_pkg::lc3b_reg'(3'($urandom));
				reg_watch_on = 1'b0;
			end
			if (check_pending)
			begin
				@(negedge clk);
				if (src1_ready !== 1'b1)
					report_mismatch("src1_ready", 32'(src1_ready), 32'h1);
				if (src1_value !== chk_value)
					report_mismatch("src1_value", 32'(src1_value), 32'(chk_value));
				check_pending = 1'b0;
			end
			else if (completion_on && !rst && !mispredict && $urandom_range(2, 0) == 0)
			begin
				n_open = 0;
				idx = -1;
				for (int i = 0; i < model_q.size(); i++)
					if (!model_q[i].done)
						n_open++;
				pick = (n_open > 0) ? int'($urandom_range(n_open - 1, 0)) : -1;
				for (int i = 0; i < model_q.size(); i++)
				begin
					if (!model_q[i].done && pick == 0)
						idx = i;
					if (!model_q[i].done)
						pick--;
				end
				if (idx >= 0)
				begin
					e = model_q[idx];
					e.value = data_width'($urandom);
					e.done = 1'b1;
					model_q[idx] = e;
					cdb_valid = 1'b1;
					cdb_tag = e.tag;
					cdb_value = e.value;
					src1_tag = e.tag;
					chk_value = e.value;
					check_pending = 1'b1;
				end
			end
		end
	end

	initial
	begin
		logic got;
		rob_entry e;
		void'($urandom(seed));
		clk = 1'b0;
		rst = 1'b1;
		disp_req = 1'b0;
		disp_inst = lc3b_rob_pkg::op_br;
		disp_dest = lc3b_rob_pkg::r0;
		disp_value = '0;
		disp_predict = 1'b0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_value = '0;
		src1_tag = '0;
		src2_tag = '0;
		reg_sel = lc3b_rob_pkg::r0;
		pend = '0;
		model_tail = '0;
		ack_q = 1'b0;
		completion_on = 1'b0;
		reg_watch_on = 1'b0;
		reg_watch = lc3b_rob_pkg::r0;
		errors = 0;
		failures = 0;
		commits = 0;
		mispredicts = 0;
		for (int r = 0; r < 8; r++)
			model_regs[r] = '0;
		@(posedge clk);
		check_reset_state();
		@(posedge clk);
		#(drive_delay);
		rst = 1'b0;

		// fill with unfinished entries so that the next one stalls.
		for (int i = 0; i < depth; i++)
			dispatch_one(random_entry(0, 1'b1, lc3b_rob_pkg::op_add));
		if (model_q.size() != depth)
			report_failure("buffer did not take a full set of entries");
		send_request(random_entry(0, 1'b1, lc3b_rob_pkg::op_ldr));
		wait_ack(stall_cycles, got);
		if (got)
			report_failure("disp_ack while the buffer was full");
		completion_on = 1'b1; // head can now complete and retire.
		wait_ack(ack_timeout, got);
		if (!got)
			report_failure("no disp_ack after the head retired");
		release_request();

		for (int i = 0; i < num_random && failures == 0; i++)
		begin
			e = random_entry(i, 1'b0, lc3b_rob_pkg::op_br);
			dispatch_one(e);
		end
		drain();
		if (mispredicts == 0)
			report_failure("no branch mispredict was seen");

		$display("errors: %0d, other failures: %0d, commits: %0d, mispredicts: %0d",
			errors, failures, commits, mispredicts);
		if (errors == 0 && failures == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* verilog.f */
lc3b_rob_pkg.sv
rob_storage.sv
rob_dispatch.sv
rob_commit.sv
arch_regfile.sv
rob_top.sv
tb_rob.sv

/* Makefile */
# Verilator build and run of the reorder buffer testbench.

VERILATOR ?= verilator
TOP       ?= tb_rob
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(VERILATOR), run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
